//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_core_top
RTL_TOP    ?= core_top
FILELIST   ?= files.f
LOG        ?= sim.log
BIN        := obj_dir/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: build
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- dv/tb_core_top.sv
// integer core testbench

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module tb_core_top;

    localparam int N_SEED     = 31;     // one addi per register
    localparam int N_RAND     = 200;    // random back to back alu ops
    localparam int N_DIRECTED = 80;     // csr, counter, illegal, flush and debug cycles
    localparam int TIMEOUT_NS = (N_SEED + N_RAND + N_DIRECTED + 50) * 4;

    // expected retire outputs for one issue cycle
    typedef struct packed {
        logic                  wb_valid;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] data;
        logic                  illegal;
    } exp_t;

    logic                  clk_i;
    logic                  rstn_i;
    logic                  instr_valid_i;
    logic [31:0]           instr_i;
    logic [4:0]            dbg_reg_addr_i;
    logic                  wb_valid_o;
    logic [4:0]            wb_rd_o;
    logic [`CORE_XLEN-1:0] wb_data_o;
    logic                  illegal_o;
    logic [`CORE_XLEN-1:0] dbg_reg_data_o;

    logic [`CORE_XLEN-1:0] model_rf [32];            // architectural state of the model
    logic [`CORE_XLEN-1:0] model_mscratch;
    logic [`CORE_XLEN-1:0] model_instret;
    logic [`CORE_XLEN-1:0] model_csrret;
    logic [31:0]           cyc_cnt = '0;             // edges seen since reset release
    logic [31:0]           rng_state = 32'h5878;
    exp_t                  exp_q[$];                 // one entry per driven cycle
    string                 name_q[$];
    string                 test_name = "reset";
    int                    err_cnt = 0;
    exp_t                  cmp_e;
    string                 cmp_name;

    core_top dut (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .dbg_reg_addr_i (dbg_reg_addr_i),
        .wb_valid_o     (wb_valid_o),
        .wb_rd_o        (wb_rd_o),
        .wb_data_o      (wb_data_o),
        .illegal_o      (illegal_o),
        .dbg_reg_data_o (dbg_reg_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        if (rstn_i)
            cyc_cnt <= cyc_cnt + 32'd1;   // tracks mcycle
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [4:0] rs1, input logic [11:0] csr);
        return {csr, rs1, f3, rd, 7'b1110011};
    endfunction

    // architectural result of one instruction, updates the model state
    function automatic exp_t ref_model(input logic [31:0] ins);
        exp_t                  e;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [2:0]            f3;
        logic [11:0]           csr;
        logic [`CORE_XLEN-1:0] imm;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] res;
        logic [`CORE_XLEN-1:0] old_v;
        logic [`CORE_XLEN-1:0] new_v;
        logic                  legal;
        logic                  is_csr;
        e      = '0;
        rd     = ins[11:7];
        rs1    = ins[19:15];
        f3     = ins[14:12];
        csr    = ins[31:20];
        imm    = {{20{ins[31]}}, ins[31:20]};
        a      = model_rf[rs1];
        b      = model_rf[ins[24:20]];
        res    = '0;
        old_v  = '0;
        legal  = 1'b1;
        is_csr = 1'b0;
        case (ins[6:0])
            7'b0010011: begin
                case (f3)
                    3'd0:    res = a + imm;
                    3'd4:    res = a ^ imm;
                    3'd6:    res = a | imm;
                    3'd7:    res = a & imm;
                    default: legal = 1'b0;
                endcase
            end
            7'b0110011: begin
                if (ins[31:25] == 7'h20 && f3 == 3'd0)
                    res = a - b;
                else if (ins[31:25] != 7'h00)
                    legal = 1'b0;
                else begin
                    case (f3)
                        3'd0:    res = a + b;
                        3'd4:    res = a ^ b;
                        3'd6:    res = a | b;
                        3'd7:    res = a & b;
                        default: legal = 1'b0;
                    endcase
                end
            end
            7'b1110011: begin
                is_csr = (f3 == 3'd1) || (f3 == 3'd2);   // csrrw, csrrs
                legal  = is_csr;
                case (csr)
                    12'h340: old_v = model_mscratch;
                    12'hB00: old_v = cyc_cnt + 32'd1;    // value at start of execute
                    12'hB02: old_v = model_instret;
                    12'hB03: old_v = model_csrret;
                    default: legal = 1'b0;               // unmapped
                endcase
                new_v = (f3 == 3'd1) ? a : (old_v | a);
                // csrrs with x0 writes nothing, mcycle writes are not exercised
                if (legal && (f3 == 3'd1 || rs1 != 5'd0)) begin
                    case (csr)
                        12'h340: model_mscratch = new_v;
                        12'hB02: model_instret  = new_v;
                        12'hB03: model_csrret   = new_v;
                        default: ;
                    endcase
                end
                res = old_v;
            end
            default: legal = 1'b0;
        endcase
        model_instret = model_instret + 32'd1;   // every issued instruction retires
        if (legal && is_csr)
            model_csrret = model_csrret + 32'd1;
        if (legal && rd != 5'd0) begin
            model_rf[rd] = res;
            e.wb_valid   = 1'b1;
            e.rd         = rd;
            e.data       = res;
        end
        e.illegal = ~legal;
        return e;
    endfunction

    task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("ERROR %s expected %h actual %h", what, exp_v, act_v);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue(input logic [31:0] ins);
        @(negedge clk_i);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        exp_q.push_back(ref_model(ins));
        name_q.push_back(test_name);
    endtask

    task automatic idle();
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        instr_i       = lcg_next();   // junk, must be ignored
        exp_q.push_back('0);
        name_q.push_back(test_name);
    endtask

    task automatic rand_alu();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] ins;
        r   = lcg_next();
        rd  = {2'b00, r[31:29]};   // x0..x7 keeps dependencies dense
        rs1 = {2'b00, r[28:26]};
        rs2 = {2'b00, r[25:23]};
        case (r[22:19] % 4'd9)
            4'd0:    ins = enc_i(3'd0, rd, rs1, r[18:7]);
            4'd1:    ins = enc_i(3'd4, rd, rs1, r[18:7]);
            4'd2:    ins = enc_i(3'd6, rd, rs1, r[18:7]);
            4'd3:    ins = enc_i(3'd7, rd, rs1, r[18:7]);
            4'd4:    ins = enc_r(7'h00, 3'd0, rd, rs1, rs2);
            4'd5:    ins = enc_r(7'h20, 3'd0, rd, rs1, rs2);
            4'd6:    ins = enc_r(7'h00, 3'd4, rd, rs1, rs2);
            4'd7:    ins = enc_r(7'h00, 3'd6, rd, rs1, rs2);
            default: ins = enc_r(7'h00, 3'd7, rd, rs1, rs2);
        endcase
        issue(ins);
    endtask

    // ----------------------------------------------------------------------
    // compare, entry of cycle T is checked at the edge ending T+2
    // ----------------------------------------------------------------------
    initial begin
        forever begin
            @(posedge clk_i);
            if (exp_q.size() >= 3) begin
                cmp_e    = exp_q.pop_front();
                cmp_name = name_q.pop_front();
                check({cmp_name, " wb_valid"}, {31'd0, cmp_e.wb_valid}, {31'd0, wb_valid_o});
                check({cmp_name, " illegal"}, {31'd0, cmp_e.illegal}, {31'd0, illegal_o});
                if (cmp_e.wb_valid) begin
                    check({cmp_name, " wb_rd"}, {27'd0, cmp_e.rd}, {27'd0, wb_rd_o});
                    check({cmp_name, " wb_data"}, cmp_e.data, wb_data_o);
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR watchdog timeout, the test sequence did not complete");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        int          i;
        logic [31:0] r;
        rstn_i         = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        dbg_reg_addr_i = '0;
        model_mscratch = '0;
        model_instret  = '0;
        model_csrret   = '0;
        for (i = 0; i < 32; i++)
            model_rf[i] = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;

        test_name = "alu_seed";
        for (i = 1; i <= N_SEED; i++) begin
            r = lcg_next();
            issue(enc_i(3'd0, i[4:0], 5'd0, r[27:16]));
        end
        test_name = "alu_random";
        for (i = 0; i < N_RAND; i++)
            rand_alu();

        test_name = "csr_mscratch";
        issue(enc_csr(3'd1, 5'd5, 5'd3, 12'h340));    // csrrw, old value back
        issue(enc_csr(3'd2, 5'd6, 5'd4, 12'h340));    // csrrs sets bits
        issue(enc_csr(3'd2, 5'd7, 5'd0, 12'h340));    // read back

        test_name = "cnt_mcycle";
        issue(enc_csr(3'd2, 5'd8, 5'd0, 12'hB00));
        repeat (4) idle();                            // five cycles apart
        issue(enc_csr(3'd2, 5'd9, 5'd0, 12'hB00));
        test_name = "cnt_minstret";
        repeat (2) idle();                            // pipeline drained
        issue(enc_csr(3'd2, 5'd10, 5'd0, 12'hB02));
        test_name = "cnt_csrret";
        repeat (2) idle();
        issue(enc_csr(3'd2, 5'd11, 5'd0, 12'hB03));

        test_name = "cnt_write";
        repeat (2) idle();
        issue(enc_csr(3'd1, 5'd12, 5'd13, 12'hB02));  // minstret <= x13
        repeat (2) idle();
        issue(enc_csr(3'd2, 5'd14, 5'd0, 12'hB02));

        test_name = "illegal";
        issue(32'hFFFF_FFFF);                         // unknown opcode
        issue(32'h0002_A283);                         // load, not supported
        issue(enc_r(7'h00, 3'd1, 5'd3, 5'd1, 5'd2));  // sll
        issue(enc_csr(3'd1, 5'd4, 5'd1, 12'h123));    // unmapped csr
        issue(enc_csr(3'd5, 5'd6, 5'd1, 12'h340));    // csrrwi
        repeat (2) idle();
        issue(enc_csr(3'd2, 5'd15, 5'd0, 12'hB02));   // illegal ones still retire
        repeat (2) idle();
        issue(enc_csr(3'd2, 5'd16, 5'd0, 12'hB03));   // but not as csr retires
        repeat (3) idle();                            // flush pipeline

        // debug port lags its address by one cycle
        test_name      = "debug_read";
        dbg_reg_addr_i = 5'd0;
        for (i = 1; i <= 32; i++) begin
            idle();
            check($sformatf("%s x%0d", test_name, i - 1), model_rf[i - 1], dbg_reg_data_o);
            if (i < 32)
                dbg_reg_addr_i = i[4:0];
        end
        repeat (2) idle();

        if (err_cnt == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+hdl
hdl/core_csr_pkg.sv
hdl/core_isa_pkg.sv
hdl/core_decode.sv
hdl/core_execute.sv
hdl/core_result.sv
hdl/core_csr.sv
hdl/core_hpm_counters.sv
hdl/core_top.sv
dv/tb_core_top.sv

//--- hdl/core_csr.sv
// CSR file

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_csr (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  core_csr_pkg::csr_req_t req_i,
    output core_csr_pkg::csr_rsp_t rsp_o,
    output logic                   cnt_we_o,
    output logic [1:0]             cnt_sel_o,
    output logic [`CORE_CNT_W-1:0] cnt_wdata_o,
    input  logic [`CORE_CNT_W-1:0] cycle_i,
    input  logic [`CORE_CNT_W-1:0] instret_i,
    input  logic [`CORE_CNT_W-1:0] csrret_i
);
    import core_csr_pkg::*;

    logic [`CORE_XLEN-1:0] mscratch_q;
    logic [`CORE_XLEN-1:0] old_val;
    logic [`CORE_XLEN-1:0] new_val;
    logic                  hit;
    logic                  is_cnt;
    logic                  do_write;

    // ---------------------------------------------------------------------
    // address decode, read mux
    // ---------------------------------------------------------------------
    always_comb begin
        hit       = 1'b1;
        is_cnt    = 1'b1;
        cnt_sel_o = CNT_SEL_CYCLE;
        old_val   = '0;
        unique case (req_i.addr)
            CSR_MSCRATCH: begin
                old_val = mscratch_q;
                is_cnt  = 1'b0;
            end
            CSR_MCYCLE: begin
                old_val   = cycle_i;
                cnt_sel_o = CNT_SEL_CYCLE;
            end
            CSR_MINSTRET: begin
                old_val   = instret_i;
                cnt_sel_o = CNT_SEL_INSTRET;
            end
            CSR_MHPMCOUNTER3: begin
                old_val   = csrret_i;
                cnt_sel_o = CNT_SEL_CSRRET;
            end
            default: begin
                hit    = 1'b0;
                is_cnt = 1'b0;
            end
        endcase
    end

    assign new_val  = (req_i.cmd == CSR_SET) ? (old_val | req_i.wdata) : req_i.wdata;
    assign do_write = req_i.valid & hit & (req_i.cmd != CSR_NONE);

    // counters live in their own block, only the strobe goes out
    assign cnt_we_o    = do_write & is_cnt;
    assign cnt_wdata_o = new_val;

    always_comb begin
        rsp_o       = '0;
        rsp_o.rdata = old_val;   // csr instructions return the old value
        rsp_o.hit   = hit;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            mscratch_q <= '0;
        else if (do_write && !is_cnt)
            mscratch_q <= new_val;
    end

endmodule

`default_nettype wire

//--- hdl/core_csr_pkg.sv
// CSR unit types

`default_nettype none

`include "core_macros.svh"

package core_csr_pkg;

    // machine CSR addresses that are mapped
    localparam logic [11:0] CSR_MSCRATCH     = 12'h340;
    localparam logic [11:0] CSR_MCYCLE       = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET     = 12'hB02;
    localparam logic [11:0] CSR_MHPMCOUNTER3 = 12'hB03;

    // counter select on the CSR -> counter write path
    localparam logic [1:0] CNT_SEL_CYCLE   = 2'd0;
    localparam logic [1:0] CNT_SEL_INSTRET = 2'd1;
    localparam logic [1:0] CNT_SEL_CSRRET  = 2'd2;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,   // read only
        CSR_WRITE = 2'd1,   // csrrw
        CSR_SET   = 2'd2    // csrrs
    } csr_cmd_e;

    typedef struct packed {
        logic                  valid;
        csr_cmd_e              cmd;
        logic [11:0]           addr;
        logic [`CORE_XLEN-1:0] wdata;    // rs1 value
    } csr_req_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] rdata;    // value before the update
        logic                  hit;      // low for an unmapped address
    } csr_rsp_t;

    typedef struct packed {
        logic retire;       // any instruction retired
        logic csr_retire;   // a legal CSR instruction retired
    } hpm_event_t;

endpackage

`default_nettype wire

//--- hdl/core_decode.sv
// decode stage and register file

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_decode (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  logic                     instr_valid_i,
    input  logic [31:0]              instr_i,
    input  core_isa_pkg::wb_t        fwd_i,          // execute result, this cycle
    input  core_isa_pkg::wb_t        wb_i,           // retiring result, write port
    input  logic [4:0]               dbg_reg_addr_i,
    output core_isa_pkg::decoded_t   dec_o,
    output logic [`CORE_XLEN-1:0]    dbg_reg_data_o
);
    import core_isa_pkg::*;
    import core_csr_pkg::*;

    logic [`CORE_XLEN-1:0] rf_q [`CORE_NREGS];
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    decoded_t              dec_d;

    // operand read: execute forward beats the write port beats the array
    function automatic logic [`CORE_XLEN-1:0] read_operand(input logic [4:0] addr);
        logic [`CORE_XLEN-1:0] val;
        if (addr == 5'd0)
            val = '0;
        else if (fwd_i.valid && fwd_i.we && fwd_i.rd == addr)
            val = fwd_i.data;   // instruction from T-1
        else if (wb_i.valid && wb_i.we && wb_i.rd == addr)
            val = wb_i.data;    // instruction from T-2
        else
            val = rf_q[addr];
        return val;
    endfunction

    assign opcode  = instr_i[6:0];
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign rs1     = instr_i[19:15];
    assign rs2     = instr_i[24:20];
    assign imm_i   = {{(`CORE_XLEN-12){instr_i[31]}}, instr_i[31:20]};

    always_comb begin
        rs1_val = read_operand(rs1);
        rs2_val = read_operand(rs2);
    end

    // ---------------------------------------------------------------------
    // instruction decode
    // ---------------------------------------------------------------------
    always_comb begin
        dec_d           = '0;
        dec_d.valid     = instr_valid_i;
        dec_d.rd        = instr_i[11:7];
        dec_d.alu_op    = ALU_ADD;
        dec_d.csr_cmd   = CSR_NONE;
        dec_d.csr_addr  = instr_i[31:20];
        dec_d.operand_a = rs1_val;
        dec_d.we        = 1'b1;
        unique case (opcode)
            OPC_OP_IMM: begin
                dec_d.operand_b = imm_i;
                unique case (funct3)
                    F3_ADD:  dec_d.alu_op = ALU_ADD;
                    F3_XOR:  dec_d.alu_op = ALU_XOR;
                    F3_OR:   dec_d.alu_op = ALU_OR;
                    F3_AND:  dec_d.alu_op = ALU_AND;
                    default: dec_d.illegal = 1'b1;   // shifts, slti not supported
                endcase
            end
            OPC_OP: begin
                dec_d.operand_b = rs2_val;
                if (funct7 == F7_SUB && funct3 == F3_ADD)
                    dec_d.alu_op = ALU_SUB;
                else if (funct7 != F7_BASE)
                    dec_d.illegal = 1'b1;
                else begin
                    unique case (funct3)
                        F3_ADD:  dec_d.alu_op = ALU_ADD;
                        F3_XOR:  dec_d.alu_op = ALU_XOR;
                        F3_OR:   dec_d.alu_op = ALU_OR;
                        F3_AND:  dec_d.alu_op = ALU_AND;
                        default: dec_d.illegal = 1'b1;
                    endcase
                end
            end
            OPC_SYSTEM: begin
                dec_d.is_csr = 1'b1;
                dec_d.alu_op = ALU_PASS_B;   // old CSR value is the result
                unique case (funct3)
                    F3_CSRRW: dec_d.csr_cmd = CSR_WRITE;
                    // csrrs with rs1 = x0 is a pure read, counters keep counting
                    F3_CSRRS: dec_d.csr_cmd = (rs1 == 5'd0) ? CSR_NONE : CSR_SET;
                    default:  dec_d.illegal = 1'b1;
                endcase
            end
            default: dec_d.illegal = 1'b1;
        endcase
        if (dec_d.illegal) begin
            dec_d.we     = 1'b0;   // retires with no writeback
            dec_d.is_csr = 1'b0;
        end
    end

    // ---------------------------------------------------------------------
    // decode register, register file, debug read
    // ---------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            dec_o          <= '0;
            dbg_reg_data_o <= '0;
            for (int i = 0; i < `CORE_NREGS; i++)
                rf_q[i] <= '0;
        end else begin
            dec_o          <= dec_d;
            dbg_reg_data_o <= rf_q[dbg_reg_addr_i];   // raw array, one cycle late
            if (wb_i.valid && wb_i.we && wb_i.rd != 5'd0)
                rf_q[wb_i.rd] <= wb_i.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_execute.sv
// execute stage

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_execute (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  core_isa_pkg::decoded_t dec_i,
    output core_csr_pkg::csr_req_t csr_req_o,
    input  core_csr_pkg::csr_rsp_t csr_rsp_i,
    output core_isa_pkg::wb_t      fwd_o,      // combinational, to decode
    output core_isa_pkg::wb_t      res_o       // registered, to result
);
    import core_isa_pkg::*;

    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_res;
    logic                  csr_miss;

    // CSR request goes out in the execute cycle, answer comes back same cycle
    always_comb begin
        csr_req_o       = '0;
        csr_req_o.valid = dec_i.valid & dec_i.is_csr & ~dec_i.illegal;
        csr_req_o.cmd   = dec_i.csr_cmd;
        csr_req_o.addr  = dec_i.csr_addr;
        csr_req_o.wdata = dec_i.operand_a;   // rs1
    end

    assign csr_miss = csr_req_o.valid & ~csr_rsp_i.hit;   // unmapped CSR
    assign alu_b    = dec_i.is_csr ? csr_rsp_i.rdata : dec_i.operand_b;

    // ---------------------------------------------------------------------
    // ALU
    // ---------------------------------------------------------------------
    always_comb begin
        unique case (dec_i.alu_op)
            ALU_ADD:    alu_res = dec_i.operand_a + alu_b;
            ALU_SUB:    alu_res = dec_i.operand_a - alu_b;
            ALU_XOR:    alu_res = dec_i.operand_a ^ alu_b;
            ALU_OR:     alu_res = dec_i.operand_a | alu_b;
            ALU_AND:    alu_res = dec_i.operand_a & alu_b;
            ALU_PASS_B: alu_res = alu_b;
            default:    alu_res = '0;
        endcase
    end

    always_comb begin
        fwd_o         = '0;
        fwd_o.valid   = dec_i.valid;
        fwd_o.we      = dec_i.we & ~csr_miss;
        fwd_o.rd      = dec_i.rd;
        fwd_o.data    = alu_res;
        fwd_o.illegal = dec_i.illegal | csr_miss;
        fwd_o.is_csr  = dec_i.is_csr;
    end

    // execute -> result register
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i)
            res_o <= '0;
        else
            res_o <= fwd_o;
    end

endmodule

`default_nettype wire

//--- hdl/core_hpm_counters.sv
// hardware performance counters

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_hpm_counters (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  core_csr_pkg::hpm_event_t evt_i,
    input  logic                     we_i,
    input  logic [1:0]               sel_i,
    input  logic [`CORE_CNT_W-1:0]   wdata_i,
    output logic [`CORE_CNT_W-1:0]   cycle_o,
    output logic [`CORE_CNT_W-1:0]   instret_o,
    output logic [`CORE_CNT_W-1:0]   csrret_o
);
    import core_csr_pkg::*;

    logic wr_cycle;
    logic wr_instret;
    logic wr_csrret;

    assign wr_cycle   = we_i & (sel_i == CNT_SEL_CYCLE);
    assign wr_instret = we_i & (sel_i == CNT_SEL_INSTRET);
    assign wr_csrret  = we_i & (sel_i == CNT_SEL_CSRRET);

    // a CSR write wins over the increment of that cycle
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cycle_o   <= '0;
            instret_o <= '0;
            csrret_o  <= '0;
        end else begin
            cycle_o   <= wr_cycle ? wdata_i : cycle_o + 1'b1;
            instret_o <= wr_instret ? wdata_i
                       : instret_o + {{(`CORE_CNT_W-1){1'b0}}, evt_i.retire};
            csrret_o  <= wr_csrret ? wdata_i
                       : csrret_o + {{(`CORE_CNT_W-1){1'b0}}, evt_i.csr_retire};
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_isa_pkg.sv
// instruction set subset and pipeline types

`default_nettype none

`include "core_macros.svh"

package core_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // funct3 for the integer ops and the two CSR ops
    localparam logic [2:0] F3_ADD   = 3'b000;   // also sub
    localparam logic [2:0] F3_XOR   = 3'b100;
    localparam logic [2:0] F3_OR    = 3'b110;
    localparam logic [2:0] F3_AND   = 3'b111;
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // CSR read value goes through here
    } alu_op_e;

    // decode -> execute
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic                   is_csr;
        alu_op_e                alu_op;
        core_csr_pkg::csr_cmd_e csr_cmd;
        logic [11:0]            csr_addr;
        logic [4:0]             rd;
        logic                   we;
        logic [`CORE_XLEN-1:0]  operand_a;
        logic [`CORE_XLEN-1:0]  operand_b;   // immediate or rs2
    } decoded_t;

    // execute -> result, result -> decode, execute forward
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] data;
        logic                  illegal;
        logic                  is_csr;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/core_macros.svh
// core sizing macros

`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ---------------------------------------------------------------------
// datapath
// ---------------------------------------------------------------------

// integer register and ALU width
`define CORE_XLEN 32

// architectural registers, x0 hardwired to zero
`define CORE_NREGS 32

// ---------------------------------------------------------------------
// performance counters
// ---------------------------------------------------------------------

// counters are XLEN wide so a CSR read returns them whole
`define CORE_CNT_W `CORE_XLEN

`endif

//--- hdl/core_result.sv
// result stage, retire and writeback

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_result (
    input  logic                     clk_i,
    input  logic                     rstn_i,
    input  core_isa_pkg::wb_t        res_i,
    output core_isa_pkg::wb_t        wb_o,         // register file write port
    output core_csr_pkg::hpm_event_t evt_o,
    output logic                     wb_valid_o,
    output logic [4:0]               wb_rd_o,
    output logic [`CORE_XLEN-1:0]    wb_data_o,
    output logic                     illegal_o
);

    logic                  wr_en;
    logic [4:0]            last_rd_q;      // observed port holds between writes
    logic [`CORE_XLEN-1:0] last_data_q;

    // x0 writes are dropped here, illegal never writes
    assign wr_en = res_i.valid & res_i.we & ~res_i.illegal & (res_i.rd != 5'd0);

    always_comb begin
        wb_o    = res_i;
        wb_o.we = wr_en;
    end

    assign wb_valid_o = wr_en;
    assign wb_rd_o    = wr_en ? res_i.rd : last_rd_q;
    assign wb_data_o  = wr_en ? res_i.data : last_data_q;
    assign illegal_o  = res_i.valid & res_i.illegal;

    always_comb begin
        evt_o            = '0;
        evt_o.retire     = res_i.valid;
        evt_o.csr_retire = res_i.valid & res_i.is_csr & ~res_i.illegal;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            last_rd_q   <= '0;
            last_data_q <= '0;
        end else if (wr_en) begin
            last_rd_q   <= res_i.rd;
            last_data_q <= res_i.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
// integer core top level

`timescale 1ns/1ps
`default_nettype none

`include "core_macros.svh"

module core_top (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  instr_valid_i,
    input  logic [31:0]           instr_i,
    input  logic [4:0]            dbg_reg_addr_i,
    output logic                  wb_valid_o,
    output logic [4:0]            wb_rd_o,
    output logic [`CORE_XLEN-1:0] wb_data_o,
    output logic                  illegal_o,
    output logic [`CORE_XLEN-1:0] dbg_reg_data_o
);
    import core_isa_pkg::*;
    import core_csr_pkg::*;

    decoded_t               dec;        // decode -> execute
    wb_t                    fwd;        // execute forward
    wb_t                    res;        // execute -> result
    wb_t                    wb;         // register file write port
    csr_req_t               csr_req;
    csr_rsp_t               csr_rsp;
    hpm_event_t             evt;
    logic                   cnt_we;
    logic [1:0]             cnt_sel;
    logic [`CORE_CNT_W-1:0] cnt_wdata;
    logic [`CORE_CNT_W-1:0] cycle;
    logic [`CORE_CNT_W-1:0] instret;
    logic [`CORE_CNT_W-1:0] csrret;

    // ---------------------------------------------------------------------
    // pipeline
    // ---------------------------------------------------------------------
    core_decode u_decode (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .fwd_i          (fwd),
        .wb_i           (wb),
        .dbg_reg_addr_i (dbg_reg_addr_i),
        .dec_o          (dec),
        .dbg_reg_data_o (dbg_reg_data_o)
    );

    core_execute u_execute (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .dec_i     (dec),
        .csr_req_o (csr_req),
        .csr_rsp_i (csr_rsp),
        .fwd_o     (fwd),
        .res_o     (res)
    );

    core_result u_result (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .res_i      (res),
        .wb_o       (wb),
        .evt_o      (evt),
        .wb_valid_o (wb_valid_o),
        .wb_rd_o    (wb_rd_o),
        .wb_data_o  (wb_data_o),
        .illegal_o  (illegal_o)
    );

    // ---------------------------------------------------------------------
    // CSRs and counters
    // ---------------------------------------------------------------------
    core_csr u_csr (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_i       (csr_req),
        .rsp_o       (csr_rsp),
        .cnt_we_o    (cnt_we),
        .cnt_sel_o   (cnt_sel),
        .cnt_wdata_o (cnt_wdata),
        .cycle_i     (cycle),
        .instret_i   (instret),
        .csrret_i    (csrret)
    );

    core_hpm_counters u_hpm (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .evt_i     (evt),
        .we_i      (cnt_we),
        .sel_i     (cnt_sel),
        .wdata_i   (cnt_wdata),
        .cycle_o   (cycle),
        .instret_o (instret),
        .csrret_o  (csrret)
    );

endmodule

`default_nettype wire
